/* cache_top.f */
hdl/cache_cfg_pkg.sv
hdl/cache_types_pkg.sv
hdl/cache_ifs.sv
hdl/way_array.sv
hdl/tag_match.sv
hdl/dirty_bits.sv
hdl/cache_ctrl.sv
hdl/cache_top.sv
dv/cache_tb.sv

/* dv/cache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_tb;
    import cache_cfg_pkg::*;
    import cache_types_pkg::*;

    localparam int reset_cycles = 4;
    localparam int num_random = 16;
    localparam int timeout_slack = 20;

    logic                  clk;
    logic                  rst_n;
    logic                  req_valid;
    cache_op_e             req_op;
    logic [addr_width-1:0] req_addr;
    block_t                req_wdata;
    logic                  rsp_valid;
    logic                  rsp_hit;
    block_t                rsp_data;
    logic                  rsp_evict_dirty;

    // stimulus table, one request per entry
    string                 t_name [$];
    cache_op_e             t_op [$];
    logic [addr_width-1:0] t_addr [$];
    block_t                t_wdata [$];
    logic                  t_hit [$];
    logic                  t_chk [$];   // data is only meaningful on a hit or fill
    block_t                t_data [$];
    logic                  t_evict [$];

    logic [addr_width-1:0] filled_lines [$];
    int pend [$];                      // table indices waiting for their response
    logic [1:0] vpipe;                 // req_valid seen at the last two edges
    int seed = 75031;
    int val_errs = 0;
    int proto_errs = 0;
    int cycles = 0;
    int limit_cycles = 0;
    int chk_idx;

    // shadow copy of the cache contents, used for the random loads
    logic   sh_valid [num_sets][num_ways];
    tag_t   sh_tag [num_sets][num_ways];
    block_t sh_data [num_sets][num_ways];
    logic   sh_lru [num_sets];

    cache_top cache_top_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .req_valid       (req_valid),
        .req_op          (req_op),
        .req_addr        (req_addr),
        .req_wdata       (req_wdata),
        .rsp_valid       (rsp_valid),
        .rsp_hit         (rsp_hit),
        .rsp_data        (rsp_data),
        .rsp_evict_dirty (rsp_evict_dirty)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    function automatic logic [addr_width-1:0] line_addr(input tag_t tag, input set_idx_t set,
                                                        input logic [offset_bits-1:0] off);
        return {tag, set, off};
    endfunction

    task automatic add_entry(input string name, input cache_op_e op,
                             input logic [addr_width-1:0] addr, input block_t wdata,
                             input logic hit, input logic chk, input block_t data,
                             input logic evict);
        t_name.push_back(name);
        t_op.push_back(op);
        t_addr.push_back(addr);
        t_wdata.push_back(wdata);
        t_hit.push_back(hit);
        t_chk.push_back(chk);
        t_data.push_back(data);
        t_evict.push_back(evict);
        if (op == op_fill) begin
            filled_lines.push_back({addr[addr_width-1:offset_bits], 3'b000});
        end
    endtask

    // lookup and update of the shadow copy by the cache rules
    task automatic model_access(input cache_op_e op, input logic [addr_width-1:0] addr,
                                input block_t wdata, output logic hit, output block_t data);
        int s;
        int hw;
        int vw;
        int bit_lo;
        tag_t t;
        s = int'(addr[set_lsb +: set_bits]);
        t = addr[tag_lsb +: tag_bits];
        bit_lo = 8 * int'(addr[offset_bits-1:0]);
        hw = -1;
        for (int w = 0; w < num_ways; w++) begin
            if (sh_valid[s][w] && (sh_tag[s][w] == t)) hw = w;
        end
        hit = (hw >= 0);
        data = '0;
        if (op == op_fill) begin
            vw = !sh_valid[s][0] ? 0 : (!sh_valid[s][1] ? 1 : (sh_lru[s] ? 1 : 0));
            sh_valid[s][vw] = 1'b1;
            sh_tag[s][vw] = t;
            sh_data[s][vw] = wdata;
            sh_lru[s] = (vw == 0);      // the other way goes next
            data = wdata;
        end else if (hit) begin
            if (op == op_store) begin
                sh_data[s][hw][bit_lo +: 8] = wdata[7:0];
            end
            data = sh_data[s][hw];
            sh_lru[s] = (hw == 0);
        end
    endtask

    task automatic check_rsp(input int i);
        if (rsp_hit !== t_hit[i]) begin
            val_errs++;
            $display("Error %s: rsp_hit expected %0b, actual %0b",
                     t_name[i], t_hit[i], rsp_hit);
        end
        if (t_chk[i] && (rsp_data !== t_data[i])) begin
            val_errs++;
            $display("Error %s: rsp_data expected %h, actual %h",
                     t_name[i], t_data[i], rsp_data);
        end
        if (rsp_evict_dirty !== t_evict[i]) begin
            val_errs++;
            $display("Error %s: rsp_evict_dirty expected %0b, actual %0b",
                     t_name[i], t_evict[i], rsp_evict_dirty);
        end
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) vpipe <= '0;
        else vpipe <= {vpipe[0], req_valid};
    end

    // responses are stable at the falling edge
    always @(negedge clk) begin
        if (rst_n && (vpipe[1] || rsp_valid)) begin
            if (!vpipe[1]) begin
                proto_errs++;
                $display("response at %0t with no request two cycles before", $time);
            end else begin
                chk_idx = pend.pop_front();
                if (!rsp_valid) begin
                    proto_errs++;
                    $display("no response for %s at %0t", t_name[chk_idx], $time);
                end else begin
                    check_rsp(chk_idx);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if ((limit_cycles > 0) && (cycles > limit_cycles)) begin
            $display("run stopped after %0d cycles, responses still outstanding", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        logic hit;
        block_t data;
        int pick;
        int off;
        logic [addr_width-1:0] raddr;
        rst_n = 1'b0;
        req_valid = 1'b0;
        req_op = op_load;
        req_addr = '0;
        req_wdata = '0;
        for (int s = 0; s < num_sets; s++) begin
            sh_lru[s] = 1'b0;
            for (int w = 0; w < num_ways; w++) sh_valid[s][w] = 1'b0;
        end

        // set 5 holds tags 10..50 over time, set 9 tags 60 and 61
        add_entry("ld_miss", op_load, line_addr(23'h10, 6'd5, 3'd0), '0, 1'b0, 1'b0, '0, 1'b0);
        add_entry("fill_a", op_fill, line_addr(23'h10, 6'd5, 3'd0), 64'h1111_2222_3333_4444,
                  1'b0, 1'b1, 64'h1111_2222_3333_4444, 1'b0);
        add_entry("ld_a_hit", op_load, line_addr(23'h10, 6'd5, 3'd4), '0,
                  1'b1, 1'b1, 64'h1111_2222_3333_4444, 1'b0);
        add_entry("fill_b", op_fill, line_addr(23'h20, 6'd5, 3'd0), 64'hbbbb_0000_bbbb_0001,
                  1'b0, 1'b1, 64'hbbbb_0000_bbbb_0001, 1'b0);
        add_entry("ld_a2", op_load, line_addr(23'h10, 6'd5, 3'd0), '0,
                  1'b1, 1'b1, 64'h1111_2222_3333_4444, 1'b0);
        add_entry("ld_b", op_load, line_addr(23'h20, 6'd5, 3'd1), '0,
                  1'b1, 1'b1, 64'hbbbb_0000_bbbb_0001, 1'b0);
        add_entry("ld_c_miss", op_load, line_addr(23'h30, 6'd5, 3'd0), '0,
                  1'b0, 1'b0, '0, 1'b0);
        add_entry("ld_a3", op_load, line_addr(23'h10, 6'd5, 3'd0), '0,
                  1'b1, 1'b1, 64'h1111_2222_3333_4444, 1'b0);
        add_entry("fill_c", op_fill, line_addr(23'h30, 6'd5, 3'd0), 64'hcccc_1234_cccc_5678,
                  1'b0, 1'b1, 64'hcccc_1234_cccc_5678, 1'b0);   // b is lru and clean
        add_entry("ld_b_miss", op_load, line_addr(23'h20, 6'd5, 3'd0), '0,
                  1'b0, 1'b0, '0, 1'b0);
        add_entry("ld_a4", op_load, line_addr(23'h10, 6'd5, 3'd0), '0,
                  1'b1, 1'b1, 64'h1111_2222_3333_4444, 1'b0);
        add_entry("st_a", op_store, line_addr(23'h10, 6'd5, 3'd2), 64'h0000_0000_0000_00ab,
                  1'b1, 1'b1, 64'h1111_2222_33ab_4444, 1'b0);
        add_entry("ld_a_after_st", op_load, line_addr(23'h10, 6'd5, 3'd0), '0,
                  1'b1, 1'b1, 64'h1111_2222_33ab_4444, 1'b0);
        add_entry("fill_d", op_fill, line_addr(23'h40, 6'd5, 3'd0), 64'hdddd_eeee_dddd_eeee,
                  1'b0, 1'b1, 64'hdddd_eeee_dddd_eeee, 1'b0);
        add_entry("ld_d", op_load, line_addr(23'h40, 6'd5, 3'd7), '0,
                  1'b1, 1'b1, 64'hdddd_eeee_dddd_eeee, 1'b0);
        add_entry("fill_e", op_fill, line_addr(23'h50, 6'd5, 3'd0), 64'h0e0e_5555_0e0e_5555,
                  1'b0, 1'b1, 64'h0e0e_5555_0e0e_5555, 1'b1);   // evicts the stored line
        add_entry("ld_a_gone", op_load, line_addr(23'h10, 6'd5, 3'd0), '0,
                  1'b0, 1'b0, '0, 1'b0);
        add_entry("ld_e", op_load, line_addr(23'h50, 6'd5, 3'd0), '0,
                  1'b1, 1'b1, 64'h0e0e_5555_0e0e_5555, 1'b0);
        add_entry("fill_f", op_fill, line_addr(23'h60, 6'd9, 3'd0), 64'h0f0e_0d0c_0b0a_0908,
                  1'b0, 1'b1, 64'h0f0e_0d0c_0b0a_0908, 1'b0);
        add_entry("st_f", op_store, line_addr(23'h60, 6'd9, 3'd7), 64'hffff_ffff_ffff_ff5a,
                  1'b1, 1'b1, 64'h5a0e_0d0c_0b0a_0908, 1'b0);
        add_entry("fill_g", op_fill, line_addr(23'h61, 6'd9, 3'd0), 64'h6161_6161_7272_7272,
                  1'b0, 1'b1, 64'h6161_6161_7272_7272, 1'b0);

        for (int i = 0; i < t_name.size(); i++) begin
            model_access(t_op[i], t_addr[i], t_wdata[i], hit, data);
        end
        for (int k = 0; k < num_random; k++) begin
            pick = int'($unsigned($random(seed)) % filled_lines.size());
            off = $random(seed);
            raddr = filled_lines[pick];
            raddr[offset_bits-1:0] = off[offset_bits-1:0];
            model_access(op_load, raddr, '0, hit, data);
            add_entry($sformatf("rand_ld_%0d", k), op_load, raddr, '0, hit, hit, data, 1'b0);
        end
        limit_cycles = reset_cycles + t_name.size() + timeout_slack;

        repeat (reset_cycles) @(posedge clk);
        #1 rst_n = 1'b1;

        // back to back, one request per cycle
        for (int i = 0; i < t_name.size(); i++) begin
            @(posedge clk);
            #1;
            req_valid = 1'b1;
            req_op = t_op[i];
            req_addr = t_addr[i];
            req_wdata = t_wdata[i];
            pend.push_back(i);
        end
        @(posedge clk);
        #1 req_valid = 1'b0;

        while (pend.size() != 0) @(posedge clk);
        repeat (3) @(posedge clk);   // room for a stray response

        $display("errors: %0d value, %0d protocol, over %0d requests",
                 val_errs, proto_errs, t_name.size());
        if ((val_errs + proto_errs) == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/cache_cfg_pkg.sv */
`default_nettype none

package cache_cfg_pkg;

    // request address and data block
    localparam int addr_width = 32;
    localparam int block_bits = 64;
    localparam int block_bytes = block_bits / 8;

    // organisation of the slice
    localparam int num_sets = 64;
    localparam int num_ways = 2;

    // address split, low to high: byte offset, set index, tag
    localparam int offset_bits = $clog2(block_bytes);  // 3
    localparam int set_bits = $clog2(num_sets);        // 6
    localparam int tag_bits = addr_width - set_bits - offset_bits;  // 23

    // bit position of each field inside an address
    localparam int set_lsb = offset_bits;
    localparam int tag_lsb = offset_bits + set_bits;

endpackage

`default_nettype wire

/* hdl/cache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   req_valid,
    input  cache_types_pkg::cache_op_e             req_op,
    input  logic [cache_cfg_pkg::addr_width-1:0]   req_addr,
    input  cache_types_pkg::block_t                req_wdata,
    output cache_types_pkg::set_idx_t              rd_set,
    way_lookup_if.ctrl                             lk,
    input  cache_types_pkg::block_t                rd_block [cache_cfg_pkg::num_ways],
    array_wr_if.master                             tag_wr,
    array_wr_if.master                             data_wr,
    output cache_types_pkg::set_idx_t              dirty_set_idx,
    output cache_types_pkg::way_mask_t             set_dirty,
    output cache_types_pkg::way_mask_t             clr_dirty,
    input  cache_types_pkg::way_mask_t             dirty,
    output logic                                   rsp_valid,
    output logic                                   rsp_hit,
    output cache_types_pkg::block_t                rsp_data,
    output logic                                   rsp_evict_dirty
);
    import cache_cfg_pkg::*;
    import cache_types_pkg::*;

    // stage 2 request
    logic                  s2_valid;
    cache_op_e             s2_op;
    logic [addr_width-1:0] s2_addr;
    block_t                s2_wdata;

    tag_t                   s2_tag;
    set_idx_t               s2_set;
    logic [offset_bits-1:0] s2_off;

    logic [num_sets-1:0] lru;   // per set, way to replace next

    block_t    sel_block;
    block_t    merged;
    way_mask_t valid_way;
    way_mask_t use_way;
    logic      store_hit;
    logic      do_fill;
    logic      evict;

    assign rd_set = req_addr[set_lsb +: set_bits];   // arrays read during stage 1

    assign s2_tag = s2_addr[tag_lsb +: tag_bits];
    assign s2_set = s2_addr[set_lsb +: set_bits];
    assign s2_off = s2_addr[offset_bits-1:0];

    assign lk.cmp_tag = s2_tag;
    assign lk.lru_way = lru[s2_set];

    assign store_hit = s2_valid && (s2_op == op_store) && lk.hit;
    assign do_fill = s2_valid && (s2_op == op_fill);

    always_comb begin
        sel_block = '0;
        for (int w = 0; w < num_ways; w++) begin
            valid_way[w] = lk.rd_entries[w].valid;
            if (lk.hit_way[w]) begin
                sel_block |= rd_block[w];
            end
        end
    end

    // store data replaces one byte of the hit block
    always_comb begin
        merged = sel_block;
        merged[{s2_off, 3'b000} +: 8] = s2_wdata[7:0];
    end

    assign use_way = do_fill ? lk.victim_way : lk.hit_way;
    assign evict = do_fill && ((lk.victim_way & valid_way & dirty) != '0);

    always_comb begin
        tag_wr.we = do_fill;
        tag_wr.wmask = lk.victim_way;
        tag_wr.waddr = s2_set;
        tag_wr.wdata = '{valid: 1'b1, tag: s2_tag};

        data_wr.we = do_fill || store_hit;
        data_wr.wmask = use_way;
        data_wr.waddr = s2_set;
        data_wr.wdata = do_fill ? s2_wdata : merged;
    end

    assign dirty_set_idx = s2_set;
    assign set_dirty = store_hit ? lk.hit_way : '0;
    assign clr_dirty = do_fill ? lk.victim_way : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s2_valid <= 1'b0;
            lru <= '0;
            rsp_valid <= 1'b0;
            rsp_hit <= 1'b0;
            rsp_evict_dirty <= 1'b0;
        end else begin
            s2_valid <= req_valid;
            rsp_valid <= s2_valid;
            rsp_hit <= s2_valid && lk.hit;
            rsp_evict_dirty <= evict;
            if (s2_valid && (lk.hit || do_fill)) begin
                lru[s2_set] <= use_way[0];   // way 0 used, so way 1 goes next
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            s2_op <= req_op;
            s2_addr <= req_addr;
            s2_wdata <= req_wdata;
        end
        if (s2_valid) begin
            // fills echo the new block, stores the merged one
            rsp_data <= do_fill ? s2_wdata : (store_hit ? merged : sel_block);
        end
    end

    a_wr_needs_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        (tag_wr.we || data_wr.we || (set_dirty != '0) || (clr_dirty != '0)) |-> s2_valid
    );

endmodule

`default_nettype wire

/* hdl/cache_ifs.sv */
`timescale 1ns/1ps
`default_nettype none

// lookup of one set, tag array read data in and hit/victim decision out
interface way_lookup_if;
    import cache_cfg_pkg::*;
    import cache_types_pkg::*;

    tag_entry_t rd_entries [num_ways];  // registered read of the tag array
    tag_t       cmp_tag;                // tag of the request in stage 2
    logic       lru_way;                // way to replace when the set is full
    way_mask_t  hit_way;                // one-hot, or zero on a miss
    logic       hit;
    way_mask_t  victim_way;             // always one-hot

    modport ctrl (
        input  rd_entries,
        input  hit_way,
        input  hit,
        input  victim_way,
        output cmp_tag,
        output lru_way
    );

    modport match (
        input  rd_entries,
        input  cmp_tag,
        input  lru_way,
        output hit_way,
        output hit,
        output victim_way
    );
endinterface

// write port of a way array, one entry per masked way
interface array_wr_if #(
    parameter type entry_t = cache_types_pkg::block_t
);
    import cache_types_pkg::*;

    logic      we;
    way_mask_t wmask;
    set_idx_t  waddr;
    entry_t    wdata;

    modport master (output we, output wmask, output waddr, output wdata);
    modport slave (input we, input wmask, input waddr, input wdata);
endinterface

`default_nettype wire

/* hdl/cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_top (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 req_valid,
    input  cache_types_pkg::cache_op_e           req_op,
    input  logic [cache_cfg_pkg::addr_width-1:0] req_addr,
    input  cache_types_pkg::block_t              req_wdata,   // stores use the low byte
    output logic                                 rsp_valid,
    output logic                                 rsp_hit,
    output cache_types_pkg::block_t              rsp_data,
    output logic                                 rsp_evict_dirty
);
    import cache_cfg_pkg::*;
    import cache_types_pkg::*;

    set_idx_t  rd_set;
    block_t    rd_block [num_ways];
    set_idx_t  dirty_set_idx;
    way_mask_t set_dirty;
    way_mask_t clr_dirty;
    way_mask_t dirty;

    way_lookup_if lk ();
    array_wr_if #(.entry_t(tag_entry_t)) tag_wr ();
    array_wr_if #(.entry_t(block_t)) data_wr ();

    cache_ctrl u_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .req_valid       (req_valid),
        .req_op          (req_op),
        .req_addr        (req_addr),
        .req_wdata       (req_wdata),
        .rd_set          (rd_set),
        .lk              (lk),
        .rd_block        (rd_block),
        .tag_wr          (tag_wr),
        .data_wr         (data_wr),
        .dirty_set_idx   (dirty_set_idx),
        .set_dirty       (set_dirty),
        .clr_dirty       (clr_dirty),
        .dirty           (dirty),
        .rsp_valid       (rsp_valid),
        .rsp_hit         (rsp_hit),
        .rsp_data        (rsp_data),
        .rsp_evict_dirty (rsp_evict_dirty)
    );

    // tag entries, valid bits cleared by reset
    way_array #(
        .entry_t        (tag_entry_t),
        .depth          (num_sets),
        .clear_on_reset (1'b1)
    ) tag_arr (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_addr (rd_set),
        .wr      (tag_wr),
        .rd_data (lk.rd_entries)
    );

    way_array #(
        .entry_t        (block_t),
        .depth          (num_sets),
        .clear_on_reset (1'b0)
    ) data_arr (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_addr (rd_set),
        .wr      (data_wr),
        .rd_data (rd_block)
    );

    tag_match u_match (
        .lk (lk)
    );

    dirty_bits u_dirty (
        .clk       (clk),
        .rst_n     (rst_n),
        .set_idx   (dirty_set_idx),
        .set_dirty (set_dirty),
        .clr_dirty (clr_dirty),
        .dirty     (dirty)
    );

endmodule

`default_nettype wire

/* hdl/cache_types_pkg.sv */
`default_nettype none

package cache_types_pkg;

    import cache_cfg_pkg::*;

    typedef logic [tag_bits-1:0] tag_t;

    // one tag array entry, valid sits above the tag
    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    typedef logic [block_bits-1:0] block_t;

    // one bit per way, used for hits, victims, write masks and dirty flags
    typedef logic [num_ways-1:0] way_mask_t;

    typedef logic [set_bits-1:0] set_idx_t;

    // request kinds, a store writes the low byte of the request data
    typedef enum logic [1:0] {
        op_load  = 2'd0,
        op_store = 2'd1,
        op_fill  = 2'd2
    } cache_op_e;

endpackage

`default_nettype wire

/* hdl/dirty_bits.sv */
`timescale 1ns/1ps
`default_nettype none

module dirty_bits (
    input  logic                       clk,
    input  logic                       rst_n,
    input  cache_types_pkg::set_idx_t  set_idx,
    input  cache_types_pkg::way_mask_t set_dirty,   // store hit to these ways
    input  cache_types_pkg::way_mask_t clr_dirty,   // fill into these ways
    output cache_types_pkg::way_mask_t dirty
);
    import cache_cfg_pkg::*;
    import cache_types_pkg::*;

    way_mask_t flags [num_sets];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < num_sets; s++) begin
                flags[s] <= '0;
            end
        end else begin
            // masks are zero when stage 2 holds nothing to update
            flags[set_idx] <= (flags[set_idx] | set_dirty) & ~clr_dirty;
        end
    end

    // flops already hold every earlier update, so stage 2 can read them directly
    assign dirty = flags[set_idx];

    // a single request either stores or fills, never both
    a_no_set_clr_overlap: assert property (
        @(posedge clk) disable iff (!rst_n) (set_dirty & clr_dirty) == '0
    );

endmodule

`default_nettype wire

/* hdl/tag_match.sv */
`timescale 1ns/1ps
`default_nettype none

module tag_match (
    way_lookup_if.match lk
);
    import cache_cfg_pkg::*;
    import cache_types_pkg::*;

    way_mask_t match_way;
    way_mask_t free_way;    // invalid ways of the set
    way_mask_t victim;

    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            match_way[w] = lk.rd_entries[w].valid && (lk.rd_entries[w].tag == lk.cmp_tag);
            free_way[w] = !lk.rd_entries[w].valid;
        end
    end

    assign lk.hit_way = match_way;
    assign lk.hit = |match_way;

    // lowest invalid way first, LRU way only when the set is full
    always_comb begin
        victim = '0;
        victim[lk.lru_way] = 1'b1;
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (free_way[w]) begin
                victim = '0;
                victim[w] = 1'b1;   // lower ways overwrite higher ones
            end
        end
    end

    assign lk.victim_way = victim;

    // refilling a line that is already present would leave two matching ways
    always_comb begin
        a_hit_onehot0: assert ($onehot0(match_way));
    end

endmodule

`default_nettype wire

/* hdl/way_array.sv */
`timescale 1ns/1ps
`default_nettype none

module way_array #(
    parameter type entry_t = cache_types_pkg::block_t,
    parameter int depth = cache_cfg_pkg::num_sets,
    parameter bit clear_on_reset = 1'b0   // tag instance clears its valid bits
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  cache_types_pkg::set_idx_t rd_addr,
    array_wr_if.slave                 wr,
    output entry_t                    rd_data [cache_cfg_pkg::num_ways]
);
    import cache_cfg_pkg::*;
    import cache_types_pkg::*;

    entry_t mem [depth][num_ways];

    way_mask_t fwd;   // ways whose write lands in the set being read

    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            fwd[w] = wr.we && wr.wmask[w] && (wr.waddr == rd_addr);
        end
    end

    if (clear_on_reset) begin : g_clr
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                for (int s = 0; s < depth; s++) begin
                    for (int w = 0; w < num_ways; w++) begin
                        mem[s][w] <= '0;
                    end
                end
                for (int w = 0; w < num_ways; w++) begin
                    rd_data[w] <= '0;
                end
            end else begin
                for (int w = 0; w < num_ways; w++) begin
                    if (wr.we && wr.wmask[w]) begin
                        mem[wr.waddr][w] <= wr.wdata;
                    end
                    rd_data[w] <= fwd[w] ? wr.wdata : mem[rd_addr][w];  // write-first
                end
            end
        end
    end else begin : g_noclr
        always_ff @(posedge clk) begin
            for (int w = 0; w < num_ways; w++) begin
                if (wr.we && wr.wmask[w]) begin
                    mem[wr.waddr][w] <= wr.wdata;
                end
                rd_data[w] <= fwd[w] ? wr.wdata : mem[rd_addr][w];
            end
        end
    end

    // the controller must always name at least one way when it writes
    a_wmask_nonzero: assert property (
        @(posedge clk) disable iff (!rst_n) wr.we |-> (wr.wmask != '0)
    );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build the cache testbench with Verilator, run it and scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --top-module cache_tb -f cache_top.f -o cache_sim \
    && ./obj_dir/cache_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log \
    && { echo "simulation failed"; exit 1; } \
    || { echo "simulation passed"; exit 0; }
